//--- logic/mext_params.svh
`ifndef MEXT_PARAMS_SVH
`define MEXT_PARAMS_SVH

// reorder buffer size, sets tag and flush mask widths
`define ROB_LEN 16

// --------------------------------------------------
// RV32M funct3 codes, bit 2 set means divide
// --------------------------------------------------
`define MUL    3'b000
`define MULH   3'b001
`define MULHSU 3'b010
`define MULHU  3'b011
`define DIV    3'b100
`define DIVU   3'b101
`define REM    3'b110
`define REMU   3'b111

`endif

//--- logic/mext_pkg.sv
`include "mext_params.svh"

package mext_pkg;

    typedef logic [31:0] word_t;                       // operand or result
    typedef logic [$clog2(`ROB_LEN)-1:0] rob_idx_t;    // rob slot
    typedef logic [6:0] preg_t;                        // physical dest reg
    typedef logic [`ROB_LEN-1:0] flush_mask_t;         // one bit per rob slot

    // values track funct3 so the issue field maps straight across
    typedef enum logic [2:0] {
        OP_MUL    = `MUL,
        OP_MULH   = `MULH,
        OP_MULHSU = `MULHSU,
        OP_MULHU  = `MULHU,
        OP_DIV    = `DIV,
        OP_DIVU   = `DIVU,
        OP_REM    = `REM,
        OP_REMU   = `REMU
    } mext_op_e;

endpackage

//--- logic/mext_if.sv
interface mext_if;
    import mext_pkg::*;

    // issue side, from controller
    logic     req_valid;
    mext_op_e op;
    word_t    src_a;
    word_t    src_b;
    rob_idx_t tag;
    preg_t    rd;
    logic     kill;        // one cycle, drops the op in flight

    // unit side
    logic     req_ready;   // high while idle
    logic     done;        // one cycle pulse, no back-pressure
    word_t    result;
    rob_idx_t done_tag;
    preg_t    done_rd;

    modport ctrl (
        output req_valid, op, src_a, src_b, tag, rd, kill,
        input  req_ready, done, result, done_tag, done_rd
    );

    modport unit (
        input  req_valid, op, src_a, src_b, tag, rd, kill,
        output req_ready, done, result, done_tag, done_rd
    );

endinterface

//--- logic/booth_mul_unit.sv
module booth_mul_unit (
    input  logic clk,
    input  logic rst,
    mext_if.unit link
);
    import mext_pkg::*;

    typedef enum logic {IDLE, CALC} state_e;

    state_e      state, state_nx;
    logic [3:0]  count;
    logic        accept;
    logic        last;          // final iteration this cycle

    logic [35:0] mcand;         // extended multiplicand from issue
    logic [32:0] mplier;        // extended multiplier from issue
    logic [35:0] mcand_r;
    mext_op_e    op_r;
    rob_idx_t    tag_r;
    preg_t       rd_r;

    logic [35:0] m1, m2, m3, m4, addend;
    logic [69:0] product;       // acc(36) | multiplier(33) | phantom(1)
    logic [69:0] sum, product_sh;

    assign accept = link.req_valid && link.req_ready;
    assign last   = (state == CALC) && (count == 4'd10);

    // --------------------------------------------------
    // control
    // --------------------------------------------------
    always_comb begin
        unique case (state)
            IDLE:    state_nx = link.req_valid ? CALC : IDLE;
            CALC:    state_nx = (link.kill || last) ? IDLE : CALC;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            count <= 4'd0;
        end else begin
            state <= state_nx;
            count <= (state == CALC && state_nx == CALC) ? count + 4'd1 : 4'd0;
        end
    end

    // --------------------------------------------------
    // operand extension by op
    // --------------------------------------------------
    always_comb begin
        case (link.op)
            OP_MULHU: mcand = {4'b0, link.src_a};
            default:  mcand = {{4{link.src_a[31]}}, link.src_a};
        endcase
        case (link.op)
            OP_MULHU, OP_MULHSU: mplier = {1'b0, link.src_b};
            default:             mplier = {link.src_b[31], link.src_b};
        endcase
    end

    // booth multiples, 36 bits keeps the sign of 4x
    assign m1 = mcand_r;
    assign m2 = mcand_r << 1;
    assign m3 = m2 + m1;
    assign m4 = mcand_r << 2;

    always_comb begin
        unique case (product[3:0])     // three multiplier bits plus the one below
            4'b0000, 4'b1111: addend = 36'b0;
            4'b0001, 4'b0010: addend = m1;
            4'b0011, 4'b0100: addend = m2;
            4'b0101, 4'b0110: addend = m3;
            4'b0111:          addend = m4;
            4'b1000:          addend = -m4;
            4'b1001, 4'b1010: addend = -m3;
            4'b1011, 4'b1100: addend = -m2;
            4'b1101, 4'b1110: addend = -m1;
        endcase
        sum        = {product[69:34] + addend, product[33:0]};
        product_sh = {{3{sum[69]}}, sum[69:3]};    // arithmetic shift by 3
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            product <= {36'b0, mplier, 1'b0};
            mcand_r <= mcand;
            op_r    <= link.op;
            tag_r   <= link.tag;
            rd_r    <= link.rd;
        end else if (state == CALC) begin
            product <= product_sh;
        end
    end

    // result comes off the shifter, the register still holds the prior step
    assign link.req_ready = (state == IDLE);
    assign link.done      = last && !link.kill;
    assign link.result    = (op_r == OP_MUL) ? product_sh[32:1] : product_sh[64:33];
    assign link.done_tag  = tag_r;
    assign link.done_rd   = rd_r;

    // iteration count never runs past the final step
    assert property (@(posedge clk) disable iff (rst)
        (state == CALC) |-> (count <= 4'd10));

endmodule

//--- logic/restoring_div_unit.sv
module restoring_div_unit (
    input  logic clk,
    input  logic rst,
    mext_if.unit link
);
    import mext_pkg::*;

    typedef enum logic [1:0] {IDLE, CALC, FIX} state_e;

    state_e      state, state_nx;
    logic [4:0]  count;
    logic        accept;

    logic        signed_op;
    logic        rem_op;
    logic [31:0] abs_a, abs_b;

    logic [32:0] rem_r;          // partial remainder
    logic [31:0] quo_r;          // dividend shifts out, quotient shifts in
    logic [31:0] dvsr_r;
    logic        neg_q_r;
    logic        neg_r_r;
    logic        rem_op_r;
    rob_idx_t    tag_r;
    preg_t       rd_r;

    logic [32:0] rem_sh;
    logic [33:0] diff;

    assign accept    = link.req_valid && link.req_ready;
    assign signed_op = (link.op == OP_DIV) || (link.op == OP_REM);
    assign rem_op    = (link.op == OP_REM) || (link.op == OP_REMU);
    assign abs_a     = (signed_op && link.src_a[31]) ? -link.src_a : link.src_a;
    assign abs_b     = (signed_op && link.src_b[31]) ? -link.src_b : link.src_b;

    // --------------------------------------------------
    // control
    // --------------------------------------------------
    always_comb begin
        case (state)
            IDLE:    state_nx = link.req_valid ? CALC : IDLE;
            CALC: begin
                if (link.kill)
                    state_nx = IDLE;
                else
                    state_nx = (count == 5'd31) ? FIX : CALC;
            end
            default: state_nx = IDLE;      // fix-up is a single cycle
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            count <= 5'd0;
        end else begin
            state <= state_nx;
            count <= (state == CALC && state_nx == CALC) ? count + 5'd1 : 5'd0;
        end
    end

    // --------------------------------------------------
    // shift-subtract datapath
    // --------------------------------------------------
    assign rem_sh = {rem_r[31:0], quo_r[31]};
    assign diff   = {1'b0, rem_sh} - {2'b0, dvsr_r};

    always_ff @(posedge clk) begin
        if (accept) begin
            rem_r    <= 33'b0;
            quo_r    <= abs_a;
            dvsr_r   <= abs_b;
            // a zero divisor must leave the all-ones quotient alone
            neg_q_r  <= signed_op && (link.src_a[31] ^ link.src_b[31]) && (link.src_b != 0);
            neg_r_r  <= signed_op && link.src_a[31];
            rem_op_r <= rem_op;
            tag_r    <= link.tag;
            rd_r     <= link.rd;
        end else if (state == CALC) begin
            if (!diff[33]) begin        // fits, keep the difference
                rem_r <= diff[32:0];
                quo_r <= {quo_r[30:0], 1'b1};
            end else begin              // restore
                rem_r <= rem_sh;
                quo_r <= {quo_r[30:0], 1'b0};
            end
        end
    end

    // sign fix-up during FIX, min/-1 falls out of the unsigned core
    always_comb begin
        if (rem_op_r)
            link.result = neg_r_r ? -rem_r[31:0] : rem_r[31:0];
        else
            link.result = neg_q_r ? -quo_r : quo_r;
    end

    assign link.req_ready = (state == IDLE);
    assign link.done      = (state == FIX) && !link.kill;
    assign link.done_tag  = tag_r;
    assign link.done_rd   = rd_r;

    assert property (@(posedge clk) disable iff (rst)
        (count != 5'd0) |-> !link.req_ready);

endmodule

//--- logic/mext_ctrl.sv
module mext_ctrl (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  mext_pkg::mext_op_e    funct3,
    input  mext_pkg::word_t       rs1_data,
    input  mext_pkg::word_t       rs2_data,
    input  mext_pkg::rob_idx_t    in_rob_idx,
    input  mext_pkg::preg_t       in_rd,
    input  logic                  mispredict,
    input  mext_pkg::flush_mask_t flush_mask,
    output logic                  out_valid,
    output mext_pkg::rob_idx_t    out_rob_idx,
    output mext_pkg::preg_t       out_rd,
    output mext_pkg::word_t       out_data,
    mext_if.ctrl                  mul_link,
    mext_if.ctrl                  div_link
);
    import mext_pkg::*;

    logic       to_div;
    logic [1:0] accept, finish, kill;     // index 0 mul, 1 div
    logic [1:0] busy_r;
    rob_idx_t   busy_tag_r [2];

    logic       hold_valid_r;
    rob_idx_t   hold_tag_r;
    preg_t      hold_rd_r;
    word_t      hold_data_r;
    logic       hold_flushed;

    // --------------------------------------------------
    // issue steering
    // --------------------------------------------------
    assign to_div   = funct3[2];
    assign in_ready = !mispredict && (to_div ? div_link.req_ready : mul_link.req_ready);

    assign mul_link.req_valid = in_valid && in_ready && !to_div;
    assign div_link.req_valid = in_valid && in_ready && to_div;
    assign mul_link.op    = funct3;
    assign mul_link.src_a = rs1_data;
    assign mul_link.src_b = rs2_data;
    assign mul_link.tag   = in_rob_idx;
    assign mul_link.rd    = in_rd;
    assign div_link.op    = funct3;
    assign div_link.src_a = rs1_data;
    assign div_link.src_b = rs2_data;
    assign div_link.tag   = in_rob_idx;
    assign div_link.rd    = in_rd;

    // --------------------------------------------------
    // busy tracking and flush
    // --------------------------------------------------
    assign accept = {div_link.req_valid && div_link.req_ready,
                     mul_link.req_valid && mul_link.req_ready};
    assign finish = {div_link.done, mul_link.done};

    always_comb begin
        for (int i = 0; i < 2; i++)
            kill[i] = busy_r[i] && mispredict && flush_mask[busy_tag_r[i]];
    end

    assign mul_link.kill = kill[0];
    assign div_link.kill = kill[1];

    always_ff @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            if (rst)
                busy_r[i] <= 1'b0;
            else if (accept[i])
                busy_r[i] <= 1'b1;
            else if (finish[i] || kill[i])
                busy_r[i] <= 1'b0;
            if (accept[i])
                busy_tag_r[i] <= in_rob_idx;
        end
    end

    // --------------------------------------------------
    // writeback merge, mul wins a tie
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst)
            hold_valid_r <= 1'b0;
        else
            hold_valid_r <= mul_link.done && div_link.done;    // drains next cycle
    end

    always_ff @(posedge clk) begin
        if (mul_link.done && div_link.done) begin
            hold_tag_r  <= div_link.done_tag;
            hold_rd_r   <= div_link.done_rd;
            hold_data_r <= div_link.result;
        end
    end

    assign hold_flushed = mispredict && flush_mask[hold_tag_r];

    always_comb begin
        out_valid   = 1'b0;
        out_rob_idx = mul_link.done_tag;
        out_rd      = mul_link.done_rd;
        out_data    = mul_link.result;
        if (hold_valid_r) begin
            out_valid   = !hold_flushed;
            out_rob_idx = hold_tag_r;
            out_rd      = hold_rd_r;
            out_data    = hold_data_r;
        end else if (mul_link.done) begin
            out_valid   = 1'b1;
        end else if (div_link.done) begin
            out_valid   = 1'b1;
            out_rob_idx = div_link.done_tag;
            out_rd      = div_link.done_rd;
            out_data    = div_link.result;
        end
    end

    // the drain cycle is never contested by a fresh result
    assert property (@(posedge clk) disable iff (rst)
        hold_valid_r |-> !mul_link.done && !div_link.done);

    assert property (@(posedge clk) disable iff (rst)
        mul_link.kill |-> !mul_link.req_ready);
    assert property (@(posedge clk) disable iff (rst)
        div_link.kill |-> !div_link.req_ready);

endmodule

//--- logic/mext_cluster.sv
module mext_cluster (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  mext_pkg::mext_op_e    funct3,
    input  mext_pkg::word_t       rs1_data,
    input  mext_pkg::word_t       rs2_data,
    input  mext_pkg::rob_idx_t    in_rob_idx,
    input  mext_pkg::preg_t       in_rd,
    input  logic                  mispredict,
    input  mext_pkg::flush_mask_t flush_mask,
    output logic                  out_valid,
    output mext_pkg::rob_idx_t    out_rob_idx,
    output mext_pkg::preg_t       out_rd,
    output mext_pkg::word_t       out_data
);

    mext_if mul_link ();    // ctrl to booth multiplier
    mext_if div_link ();    // ctrl to restoring divider

    mext_ctrl ctrl_i (.*);

    booth_mul_unit mul_i (
        .clk  (clk),
        .rst  (rst),
        .link (mul_link)
    );

    restoring_div_unit div_i (
        .clk  (clk),
        .rst  (rst),
        .link (div_link)
    );

endmodule

//--- verif/mext_tb.sv
module mext_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import mext_pkg::*;

    localparam int TIMEOUT   = 100;    // cycles per wait
    localparam int SETTLE_NS = 5;      // inputs settle after the falling edge
    localparam int MUL_LAT   = 11;
    localparam int DIV_LAT   = 33;

    logic        clk = 1'b0;
    logic        rst;
    logic        in_valid;
    logic        in_ready;
    mext_op_e    funct3;
    word_t       rs1_data;
    word_t       rs2_data;
    rob_idx_t    in_rob_idx;
    preg_t       in_rd;
    logic        mispredict;
    flush_mask_t flush_mask;
    logic        out_valid;
    rob_idx_t    out_rob_idx;
    preg_t       out_rd;
    word_t       out_data;

    int       errors = 0;
    int       tests = 0;
    rob_idx_t next_tag = '0;
    word_t    corner [4] = '{32'h8000_0000, 32'hffff_ffff, 32'h0000_0000, 32'h7fff_ffff};

    mext_cluster dut_i (.*);

    always #20 clk = ~clk;

    // --------------------------------------------------
    // typed compares
    // --------------------------------------------------
    task automatic check_data(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s, data %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_tag(input string what, input rob_idx_t got_idx, input rob_idx_t exp_idx,
                             input preg_t got_rd, input preg_t exp_rd);
        if (got_idx !== exp_idx || got_rd !== exp_rd) begin
            errors++;
            $display("Error at %0t ns: %s, rob %0d rd %0d expected rob %0d rd %0d",
                     $time, what, got_idx, got_rd, exp_idx, exp_rd);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s, got %b expected %b", $time, what, got, exp);
        end
    endtask

    // RV32M results from 64-bit arithmetic
    task automatic model_result(input mext_op_e op, input word_t a, input word_t b,
                                output word_t res);
        longint      sa;
        longint      sb;
        logic [63:0] wide;
        sa = longint'($signed(a));
        sb = longint'($signed(b));
        case (op)
            OP_MUL: begin
                wide = sa * sb;
                res  = wide[31:0];
            end
            OP_MULH: begin
                wide = sa * sb;
                res  = wide[63:32];
            end
            OP_MULHSU: begin
                wide = sa * longint'({32'b0, b});
                res  = wide[63:32];
            end
            OP_MULHU: begin
                wide = {32'b0, a} * {32'b0, b};
                res  = wide[63:32];
            end
            OP_DIV: begin
                if (b == 0)
                    wide = '1;
                else
                    wide = sa / sb;    // 2^31 wraps to min
                res = wide[31:0];
            end
            OP_REM: begin
                wide = (b == 0) ? sa : sa % sb;
                res  = wide[31:0];
            end
            OP_DIVU:   res = (b == 0) ? 32'hffff_ffff : a / b;
            default:   res = (b == 0) ? a : a % b;
        endcase
    endtask

    // --------------------------------------------------
    // handshake helpers
    // --------------------------------------------------
    task automatic issue_op(input mext_op_e op, input word_t a, input word_t b,
                            input rob_idx_t tag, input preg_t rd, output bit ok);
        int waited;
        waited     = 0;
        funct3     = op;
        rs1_data   = a;
        rs2_data   = b;
        in_rob_idx = tag;
        in_rd      = rd;
        in_valid   = 1'b1;
        #SETTLE_NS;
        while (!in_ready && waited < TIMEOUT) begin
            @(negedge clk);
            #SETTLE_NS;
            waited++;
        end
        ok = in_ready;
        if (!ok) begin
            errors++;
            $display("timeout: in_ready stayed low for %0d cycles on %s", TIMEOUT, op.name());
        end
        @(negedge clk);            // accepted on the edge just passed
        in_valid = 1'b0;
    endtask

    // counts falling edges since acceptance
    task automatic wait_output(output int cycles, output bit ok);
        cycles = 1;
        while (!out_valid && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        ok = out_valid;
        if (!ok) begin
            errors++;
            $display("timeout: out_valid never rose within %0d cycles of issue", TIMEOUT);
        end
    endtask

    task automatic run_op(input mext_op_e op, input word_t a, input word_t b,
                          input int latency);
        word_t    exp;
        rob_idx_t tag;
        preg_t    rd;
        int       cycles;
        bit       ok;
        tag      = next_tag;
        next_tag = next_tag + 1'b1;
        rd       = preg_t'($urandom_range(127, 0));
        model_result(op, a, b, exp);
        issue_op(op, a, b, tag, rd, ok);
        if (ok) begin
            wait_output(cycles, ok);
            if (ok) begin
                check_data($sformatf("%s %h, %h", op.name(), a, b), out_data, exp);
                check_tag($sformatf("%s tag echo", op.name()), out_rob_idx, tag, out_rd, rd);
                check_flag($sformatf("%s latency %0d cycles", op.name(), cycles),
                           cycles == latency, 1'b1);
            end
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests++;
        $display("%-20s %s", name, (errors == err_before) ? "ok" : "failed");
    endtask

    // --------------------------------------------------
    // directed tests
    // --------------------------------------------------
    task automatic after_reset();
        int err0;
        err0 = errors;
        check_flag("out_valid after reset", out_valid, 1'b0);
        check_flag("in_ready after reset", in_ready, 1'b1);
        report_test("after_reset", err0);
    endtask

    task automatic mul_low();
        int err0;
        err0 = errors;
        for (int i = 0; i < 8; i++)
            run_op(OP_MUL, $urandom(), $urandom(), MUL_LAT);
        for (int i = 0; i < 4; i++)
            for (int j = 0; j < 4; j++)
                run_op(OP_MUL, corner[i], corner[j], MUL_LAT);
        report_test("mul_low", err0);
    endtask

    task automatic mul_high();
        mext_op_e hi_ops [3];
        int       err0;
        hi_ops = '{OP_MULH, OP_MULHSU, OP_MULHU};
        err0   = errors;
        foreach (hi_ops[k]) begin
            for (int i = 0; i < 6; i++)
                run_op(hi_ops[k], $urandom(), $urandom(), MUL_LAT);
            for (int i = 0; i < 4; i++)
                for (int j = 0; j < 4; j++)
                    run_op(hi_ops[k], corner[i], corner[j], MUL_LAT);
        end
        report_test("mul_high", err0);
    endtask

    task automatic divide_ops();
        mext_op_e div_ops [4];
        int       err0;
        div_ops = '{OP_DIV, OP_DIVU, OP_REM, OP_REMU};
        err0    = errors;
        foreach (div_ops[k]) begin
            for (int i = 0; i < 4; i++)
                run_op(div_ops[k], $urandom(), $urandom(), DIV_LAT);
            for (int i = 0; i < 3; i++)
                run_op(div_ops[k], $urandom(), $urandom_range(100, 1), DIV_LAT);  // small divisors
            run_op(div_ops[k], $urandom(), 32'h0, DIV_LAT);
            for (int i = 0; i < 4; i++)
                for (int j = 0; j < 4; j++)
                    run_op(div_ops[k], corner[i], corner[j], DIV_LAT);
        end
        report_test("divide_ops", err0);
    endtask

    // mul issued 22 cycles after the div so both finish together
    task automatic same_cycle_finish();
        word_t    a_d, b_d, a_m, b_m, exp_d, exp_m;
        rob_idx_t tag_d, tag_m;
        preg_t    rd_d, rd_m;
        int       cycles;
        int       err0;
        bit       ok;
        err0  = errors;
        a_d   = $urandom();
        b_d   = $urandom_range(5000, 3);
        a_m   = $urandom();
        b_m   = $urandom();
        tag_d = next_tag;
        tag_m = next_tag + 1'b1;
        next_tag = next_tag + 2'd2;
        rd_d  = preg_t'($urandom_range(127, 0));
        rd_m  = preg_t'($urandom_range(127, 0));
        model_result(OP_REM, a_d, b_d, exp_d);
        model_result(OP_MUL, a_m, b_m, exp_m);
        issue_op(OP_REM, a_d, b_d, tag_d, rd_d, ok);
        repeat (21) @(negedge clk);
        issue_op(OP_MUL, a_m, b_m, tag_m, rd_m, ok);
        wait_output(cycles, ok);
        if (ok) begin
            check_flag("mul latency in tie", cycles == MUL_LAT, 1'b1);
            check_tag("mul wins the tie", out_rob_idx, tag_m, out_rd, rd_m);
            check_data("mul result in tie", out_data, exp_m);
            @(negedge clk);
            check_flag("held div result valid", out_valid, 1'b1);
            check_tag("held div tag", out_rob_idx, tag_d, out_rd, rd_d);
            check_data("held div result", out_data, exp_d);
        end
        report_test("same_cycle_finish", err0);
    endtask

    task automatic flush_mul();
        word_t    a_d, b_d, a_n, b_n, exp_d, exp_n;
        rob_idx_t tag_d, tag_m, tag_n;
        preg_t    rd_d, rd_n;
        int       cycles;
        int       err0;
        bit       ok, got_div, got_new;
        err0    = errors;
        got_div = 1'b0;
        got_new = 1'b0;
        a_d     = $urandom();
        b_d     = $urandom();
        a_n     = $urandom();
        b_n     = $urandom();
        tag_d   = next_tag;
        tag_m   = next_tag + 1'b1;
        tag_n   = next_tag + 2'd2;
        next_tag = next_tag + 2'd3;
        rd_d    = preg_t'($urandom_range(127, 0));
        rd_n    = preg_t'($urandom_range(127, 0));
        model_result(OP_DIV, a_d, b_d, exp_d);
        model_result(OP_MULHU, a_n, b_n, exp_n);
        issue_op(OP_DIV, a_d, b_d, tag_d, rd_d, ok);
        issue_op(OP_MUL, $urandom(), $urandom(), tag_m, 7'd5, ok);
        repeat (4) @(negedge clk);
        mispredict = 1'b1;
        flush_mask = flush_mask_t'(1) << tag_m;
        #SETTLE_NS;
        check_flag("in_ready during mispredict", in_ready, 1'b0);
        @(negedge clk);
        mispredict = 1'b0;
        flush_mask = '0;
        funct3     = OP_MUL;
        #SETTLE_NS;
        check_flag("mul ready after kill", in_ready, 1'b1);
        @(negedge clk);
        issue_op(OP_MULHU, a_n, b_n, tag_n, rd_n, ok);
        cycles = 0;
        while (!(got_div && got_new) && cycles < TIMEOUT) begin
            if (out_valid) begin
                if (out_rob_idx == tag_m) begin
                    errors++;
                    $display("Error at %0t ns: flushed tag %0d reached writeback", $time, tag_m);
                end else if (out_rob_idx == tag_n) begin
                    check_tag("new mul tag", out_rob_idx, tag_n, out_rd, rd_n);
                    check_data("new mul result", out_data, exp_n);
                    got_new = 1'b1;
                end else begin
                    check_tag("div beside flush", out_rob_idx, tag_d, out_rd, rd_d);
                    check_data("div beside flush", out_data, exp_d);
                    got_div = 1'b1;
                end
            end
            @(negedge clk);
            cycles++;
        end
        if (!(got_div && got_new)) begin
            errors++;
            $display("timeout: div or new mul result never came after the flush");
        end
        report_test("flush_mul", err0);
    endtask

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin
        void'($urandom(38941));
        rst        = 1'b1;
        in_valid   = 1'b0;
        funct3     = OP_MUL;
        rs1_data   = '0;
        rs2_data   = '0;
        in_rob_idx = '0;
        in_rd      = '0;
        mispredict = 1'b0;
        flush_mask = '0;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        after_reset();
        mul_low();
        mul_high();
        divide_ops();
        same_cycle_finish();
        flush_mul();

        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

//--- compile.f
+incdir+logic
logic/mext_pkg.sv
logic/mext_if.sv
logic/booth_mul_unit.sv
logic/restoring_div_unit.sv
logic/mext_ctrl.sv
logic/mext_cluster.sv
verif/mext_tb.sv
